/* source/cfg_macros.svh */
`ifndef CFG_MACROS_SVH
`define CFG_MACROS_SVH

// slave devices sharing progb, cclk and din
`define CFG_NUM_CHAN 5

// byte queue between reader and serializer, also the starting credit count
`define CFG_FIFO_DEPTH 4

// progb low time once every init line is seen low
`define CFG_PROGB_LOW_CYCLES 16

// plain SPI read, no dummy cycles
`define CFG_SPI_READ_CMD 8'h03

`endif

/* source/cfg_pkg.sv */
`include "cfg_macros.svh"

package cfg_pkg;

    typedef logic [`CFG_NUM_CHAN-1:0] chan_mask_t;  // one bit per device
    typedef logic [7:0]  cfg_byte_t;
    typedef logic [23:0] flash_addr_t;
    typedef logic [15:0] byte_count_t;              // bitstream length in bytes
    typedef logic [2:0]  credit_t;                  // holds 0 .. CFG_FIFO_DEPTH

    typedef enum logic [2:0] {
        IDLE,
        START,
        INIT_LOW,
        INIT_WAIT,
        LOAD,
        WAIT_DONE,
        DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_CMD,
        SPI_ADDR,
        SPI_DATA,
        SPI_END
    } spi_state_t;

endpackage

/* source/bitstream_if.sv */
`timescale 1ns/1ps

// byte stream from the flash reader into the serializer queue
interface bitstream_if import cfg_pkg::*; ();

    cfg_byte_t data;    // byte pushed into the queue
    logic      valid;   // one-cycle push, only with a credit in hand
    logic      last;    // marks the final bitstream byte
    logic      credit;  // one-cycle pulse, one queue slot freed

    modport source (
        output data,
        output valid,
        output last,
        input  credit
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output credit
    );

endinterface

/* source/spi_flash_reader.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module spi_flash_reader import cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  flash_addr_t base_addr,
    input  byte_count_t byte_count,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso,
    bitstream_if.source bs
);

    localparam int TX_W  = 8 + $bits(flash_addr_t);  // opcode plus address
    localparam int CNT_W = $clog2(TX_W);

    spi_state_t       state;
    logic [TX_W-1:0]  tx_sr;       // opcode and address, MSB first
    logic [6:0]       rx_sr;       // upper seven bits of the byte being received
    logic [CNT_W-1:0] bit_cnt;
    credit_t          credit_cnt;  // free slots in the serializer queue
    byte_count_t      remaining;   // bytes still to read
    logic             byte_start;
    logic             push;

    assign spi_mosi   = tx_sr[TX_W-1];
    assign byte_start = (bit_cnt[2:0] == 3'd0);

    // the eighth data bit is sampled on this edge, so the byte is complete
    assign push = (state == SPI_DATA) && !spi_sck && (bit_cnt[2:0] == 3'd7);

    assign bs.valid = push;
    assign bs.data  = {rx_sr, spi_miso};
    assign bs.last  = push && (remaining == byte_count_t'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= credit_t'(`CFG_FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt + credit_t'(bs.credit) - credit_t'(push);
        end
    end

    always_ff @(posedge clk) begin
        if (!spi_sck && state == SPI_DATA) begin
            rx_sr <= {rx_sr[5:0], spi_miso};  // sample on the rising sck edge
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SPI_IDLE;
            spi_cs_n  <= 1'b1;
            spi_sck   <= 1'b0;
            tx_sr     <= '0;
            bit_cnt   <= '0;
            remaining <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (load_en) begin
                        spi_cs_n  <= 1'b0;
                        tx_sr     <= {`CFG_SPI_READ_CMD, base_addr};
                        remaining <= byte_count;
                        bit_cnt   <= '0;
                        state     <= SPI_CMD;
                    end
                end

                SPI_CMD, SPI_ADDR: begin
                    spi_sck <= !spi_sck;
                    if (spi_sck) begin  // falling sck, next bit onto mosi
                        tx_sr   <= tx_sr << 1;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (state == SPI_CMD && bit_cnt == CNT_W'(7)) begin
                            state <= SPI_ADDR;
                        end
                        if (bit_cnt == CNT_W'(TX_W - 1)) begin
                            state <= SPI_DATA;  // bit_cnt wraps to zero here
                        end
                    end
                end

                SPI_DATA: begin
                    if (spi_sck) begin
                        spi_sck <= 1'b0;
                        if (byte_start && remaining == '0) begin
                            spi_cs_n <= 1'b1;
                            state    <= SPI_END;
                        end
                    end else if (!byte_start || credit_cnt != '0) begin
                        // sck stays low at a byte boundary without credit
                        spi_sck <= 1'b1;
                        bit_cnt <= {2'b00, bit_cnt[2:0] + 3'd1};
                        if (push) begin
                            remaining <= remaining - 1'b1;
                        end
                    end
                end

                SPI_END: begin
                    spi_sck <= 1'b0;
                    if (!load_en) begin
                        state <= SPI_IDLE;  // wait for the sequencer to leave LOAD
                    end
                end

                default: state <= SPI_IDLE;
            endcase
        end
    end

endmodule

/* source/bit_serializer.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module bit_serializer import cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      load_en,
    input  logic      busy,
    output logic      c_din,
    output logic      c_clk,
    output logic      stream_end,
    bitstream_if.sink bs
);

    localparam int PTR_W = $clog2(`CFG_FIFO_DEPTH);

    cfg_byte_t                 q_data [`CFG_FIFO_DEPTH];
    logic [`CFG_FIFO_DEPTH-1:0] q_last;
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    credit_t                   q_count;
    cfg_byte_t                 shift_sr;
    logic [2:0]                bit_cnt;
    logic                      sr_valid;  // shift register holds a byte
    logic                      sr_last;
    logic                      busy_q;
    logic                      shift_en;
    logic                      byte_done;
    logic                      pop;

    // busy is sampled so the gated clock only changes while clk is high
    assign shift_en  = sr_valid && !busy_q && load_en;
    assign byte_done = shift_en && (bit_cnt == 3'd7);
    assign pop = load_en && (q_count != '0) && (!sr_valid || (byte_done && !sr_last));

    assign c_clk = ~clk & shift_en;                  // rises mid-cycle, bit is stable
    assign c_din = sr_valid ? shift_sr[7] : 1'b1;

    always_ff @(posedge clk) begin
        if (bs.valid) begin
            q_data[wr_ptr] <= bs.data;
            q_last[wr_ptr] <= bs.last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_sr <= q_data[rd_ptr];
        end else if (shift_en) begin
            shift_sr <= shift_sr << 1;  // MSB first
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            sr_valid   <= 1'b0;
            sr_last    <= 1'b0;
            bit_cnt    <= '0;
            busy_q     <= 1'b0;
            stream_end <= 1'b0;
            bs.credit  <= 1'b0;
        end else begin
            busy_q     <= busy;
            bs.credit  <= pop;                     // slot freed, hand it back
            stream_end <= byte_done && sr_last;
            q_count    <= q_count + credit_t'(bs.valid) - credit_t'(pop);
            if (bs.valid) begin
                wr_ptr <= wr_ptr + 1'b1;           // never refused, credits bound it
            end
            if (pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                sr_valid <= 1'b1;
                sr_last  <= q_last[rd_ptr];
                bit_cnt  <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    sr_valid <= 1'b0;              // queue ran dry or stream over
                end
            end
        end
    end

endmodule

/* source/prog_sequencer.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module prog_sequencer import cfg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  chan_mask_t initb,
    input  chan_mask_t prog_done,
    input  logic       stream_end,
    output logic       c_progb,
    output logic       load_en,
    output logic       cfg_done
);

    localparam int         CNT_W    = $clog2(`CFG_PROGB_LOW_CYCLES);
    localparam chan_mask_t ALL_CHAN = '1;

    seq_state_t       state;
    chan_mask_t       initb_meta;
    chan_mask_t       initb_sync;
    chan_mask_t       done_meta;
    chan_mask_t       done_sync;
    logic [CNT_W-1:0] pulse_cnt;  // counts the extra progb low time
    logic             all_done;

    // init and done come from other clock domains on the devices
    always_ff @(posedge clk) begin
        if (reset) begin
            initb_meta <= ALL_CHAN;  // init lines idle high
            initb_sync <= ALL_CHAN;
            done_meta  <= '0;
            done_sync  <= '0;
        end else begin
            initb_meta <= initb;
            initb_sync <= initb_meta;
            done_meta  <= prog_done;
            done_sync  <= done_meta;
        end
    end

    assign all_done = (done_sync == ALL_CHAN);

    // raised in the same cycle the last device is seen done, then held
    assign cfg_done = (state == DONE) || (state == WAIT_DONE && all_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            c_progb   <= 1'b1;
            load_en   <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        c_progb <= 1'b0;  // program pulse to every device
                        state   <= START;
                    end
                end

                START: begin
                    if (initb_sync == '0) begin
                        pulse_cnt <= '0;
                        state     <= INIT_LOW;
                    end
                end

                INIT_LOW: begin
                    if (pulse_cnt == CNT_W'(`CFG_PROGB_LOW_CYCLES - 1)) begin
                        c_progb <= 1'b1;
                        state   <= INIT_WAIT;
                    end else begin
                        pulse_cnt <= pulse_cnt + 1'b1;
                    end
                end

                INIT_WAIT: begin
                    // devices clear their memory, then release init
                    if (initb_sync == ALL_CHAN) begin
                        load_en <= 1'b1;
                        state   <= LOAD;
                    end
                end

                LOAD: begin
                    if (stream_end) begin
                        load_en <= 1'b0;
                        state   <= WAIT_DONE;
                    end
                end

                WAIT_DONE: begin
                    if (all_done) begin
                        state <= DONE;
                    end
                end

                DONE: begin
                    state <= DONE;  // held until reset
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/chan_config_top.sv */
`timescale 1ns/1ps

module chan_config_top import cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  flash_addr_t base_addr,
    input  byte_count_t byte_count,
    input  chan_mask_t  initb,
    input  chan_mask_t  prog_done,
    input  logic        busy,
    output logic        c_progb,
    output logic        c_clk,
    output logic        c_din,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso,
    output logic        cfg_done
);

    logic load_en;     // high for the whole bitstream transfer
    logic stream_end;  // last configuration bit has gone out

    bitstream_if bs_if ();

    spi_flash_reader spi_flash_reader_inst (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .base_addr  (base_addr),
        .byte_count (byte_count),
        .spi_cs_n   (spi_cs_n),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .bs         (bs_if.source)
    );

    bit_serializer bit_serializer_inst (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .busy       (busy),
        .c_din      (c_din),
        .c_clk      (c_clk),
        .stream_end (stream_end),
        .bs         (bs_if.sink)
    );

    prog_sequencer prog_sequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .initb      (initb),
        .prog_done  (prog_done),
        .stream_end (stream_end),
        .c_progb    (c_progb),
        .load_en    (load_en),
        .cfg_done   (cfg_done)
    );

endmodule

/* tests/chan_config_checker.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module chan_config_checker import cfg_pkg::*; #(
    parameter bit OCCUPANCY = 1'b0  // level counts filled queue slots
) (
    input logic    clk,
    input logic    reset,
    input logic    valid,
    input logic    credit,
    input credit_t level
);

    credit_t free_slots;
    int      assert_fails = 0;

    assign free_slots = OCCUPANCY ? credit_t'(`CFG_FIFO_DEPTH) - level : level;

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        free_slots <= credit_t'(`CFG_FIFO_DEPTH))
    else begin
        $error("credit count above the queue depth");
        assert_fails++;
    end

    push_needs_credit: assert property (@(posedge clk) disable iff (reset)
        valid |-> free_slots != '0)
    else begin
        $error("byte pushed with no credit left");
        assert_fails++;
    end

endmodule

bind spi_flash_reader chan_config_checker reader_credit_chk (
    .clk    (clk),
    .reset  (reset),
    .valid  (push),
    .credit (bs.credit),
    .level  (credit_cnt)
);

bind bit_serializer chan_config_checker #(.OCCUPANCY(1'b1)) queue_credit_chk (
    .clk    (clk),
    .reset  (reset),
    .valid  (bs.valid),
    .credit (bs.credit),
    .level  (q_count)
);

/* tests/chan_config_monitor.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module chan_config_monitor import cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  byte_count_t byte_count,
    input  chan_mask_t  initb,
    input  chan_mask_t  prog_done,
    input  logic        busy,
    input  logic        c_progb,
    input  logic        c_clk,
    input  logic        c_din,
    input  logic        spi_cs_n,
    input  logic        cfg_done,
    input  logic        ref_bit,
    output int          bit_idx,
    output int          errors,
    output int          bits_checked
);

    logic pulse_tog = 1'b0;  // flips on every c_clk rise
    logic tog_seen  = 1'b0;
    logic din_cap;
    logic busy_s;
    logic progb_q;
    logic started;
    logic init_low_seen;
    logic init_high_seen;
    logic done_seen;
    logic pulse;
    int   low_cnt;
    int   total_bits;

    initial begin
        errors       = 0;
        bits_checked = 0;
        bit_idx      = 0;
    end

    assign pulse      = (pulse_tog != tog_seen);  // a pulse in the last low phase
    assign total_bits = 8 * int'(byte_count);

    task automatic report_value(input string name, input int expected, input int actual);
        $display("ERROR %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_event(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
    endtask

    always @(posedge c_clk) begin
        pulse_tog <= ~pulse_tog;
        din_cap   <= c_din;  // the device samples din here
    end

    always @(posedge clk) begin
        busy_s   <= busy;
        progb_q  <= c_progb;
        tog_seen <= pulse_tog;
        if (reset) begin
            started        <= 1'b0;
            init_low_seen  <= 1'b0;
            init_high_seen <= 1'b0;
            done_seen      <= 1'b0;
            low_cnt        <= 0;
            bit_idx        <= 0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (!started) begin
                if (c_progb !== 1'b1) report_value("c_progb", 1, c_progb);
                if (cfg_done !== 1'b0) report_value("cfg_done", 0, cfg_done);
                if (spi_cs_n !== 1'b1) report_value("spi_cs_n", 1, spi_cs_n);
            end
            if (!c_progb && initb == '0) begin
                init_low_seen <= 1'b1;
            end
            if (!c_progb && init_low_seen) begin
                low_cnt <= low_cnt + 1;
            end
            if (init_low_seen && initb == '1) begin
                init_high_seen <= 1'b1;
            end
            if (started && c_progb && !progb_q) begin
                if (!init_low_seen) begin
                    report_event("c_progb rose before every initb line went low");
                end else if (low_cnt < `CFG_PROGB_LOW_CYCLES) begin
                    report_value("c_progb low cycles", `CFG_PROGB_LOW_CYCLES, low_cnt);
                end
            end
            if (pulse) begin
                if (!init_high_seen) report_event("c_clk pulsed before init was released");
                if (busy_s) report_event("c_clk pulsed while busy was high");
                if (bit_idx >= total_bits) begin
                    report_event("more c_clk pulses than bitstream bits");
                end else if (din_cap !== ref_bit) begin
                    $display("ERROR %0t ns: c_din bit %0d expected %b got %b",
                             $time, bit_idx, ref_bit, din_cap);
                    errors++;
                end
                bit_idx <= bit_idx + 1;
                bits_checked++;
            end
            if (cfg_done && prog_done != '1) begin
                report_event("cfg_done high before every prog_done line");
            end
            if (cfg_done && !done_seen) begin
                done_seen <= 1'b1;
                if (bit_idx != total_bits) report_value("c_clk pulse count", total_bits, bit_idx);
            end
            if (done_seen && !cfg_done) begin
                report_event("cfg_done dropped before reset");
            end
        end
    end

endmodule

/* tests/chan_config_tb.sv */
`timescale 1ns/1ps
`include "cfg_macros.svh"

module chan_config_tb import cfg_pkg::*; ();

    localparam int NCH      = `CFG_NUM_CHAN;
    localparam int IMG_SIZE = 1024;

    logic        clk;
    logic        reset;
    logic        start;
    flash_addr_t base_addr;
    byte_count_t byte_count;
    chan_mask_t  initb;
    chan_mask_t  prog_done;
    logic        busy;
    logic        spi_miso;
    logic        c_progb;
    logic        c_clk;
    logic        c_din;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        cfg_done;

    cfg_byte_t   flash_mem [IMG_SIZE];
    int          low_dly [NCH];
    int          rel_dly [NCH];
    int          done_dly [NCH];
    int          cycle = 0;
    int          t_fall = -1;   // cycle c_progb went low
    int          t_rise = -1;
    int          t_bits = -1;   // cycle the whole bitstream was clocked in
    int          pulses = 0;
    int          timeouts = 0;
    int          spi_errors = 0;
    logic        busy_mode = 1'b0;
    logic        image_ready = 1'b0;
    logic        ref_bit;
    int          bit_idx;
    int          errors;
    int          bits_checked;
    int          assert_fails;
    logic [31:0] cmd_sr = '0;   // opcode and address seen on mosi
    logic [31:0] cmd_exp;
    int          mosi_bits = 0;
    int          miso_bits = 0;
    logic        prev_sck = 1'b0;

    chan_config_top chan_config_top_inst (.*);

    chan_config_monitor chan_config_monitor_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // bit k of the bitstream, MSB of each byte first
    function automatic logic expected_bit(input int k);
        flash_addr_t addr;
        addr = base_addr + flash_addr_t'(k / 8);
        return flash_mem[int'(addr) % IMG_SIZE][7 - (k % 8)];
    endfunction

    function automatic logic flash_answer(input logic [31:0] cmd, input int idx);
        flash_addr_t addr;
        addr = cmd[23:0] + flash_addr_t'(idx / 8);
        if (cmd[31:24] != `CFG_SPI_READ_CMD) begin
            return 1'b1;  // unknown opcode, miso floats high
        end
        return flash_mem[int'(addr) % IMG_SIZE][7 - (idx % 8)];
    endfunction

    always @(bit_idx or base_addr or image_ready) ref_bit = expected_bit(bit_idx);

    always @(negedge c_clk) pulses++;

    // flash: mosi taken on rising sck, next data bit put out on falling sck
    always @(negedge clk) begin
        cmd_exp = {`CFG_SPI_READ_CMD, base_addr};
        if (spi_cs_n) begin
            if (!reset && spi_sck !== 1'b0) begin
                $display("ERROR %0t ns: spi_sck expected 0 got %b", $time, spi_sck);
                spi_errors++;
            end
            mosi_bits = 0;
            miso_bits = 0;
            spi_miso  = 1'b1;
        end else if (spi_sck && !prev_sck && mosi_bits < 32) begin
            cmd_sr = {cmd_sr[30:0], spi_mosi};
            mosi_bits++;
            if (mosi_bits == 32 && cmd_sr !== cmd_exp) begin
                $display("ERROR %0t ns: spi_mosi expected %h got %h", $time, cmd_exp, cmd_sr);
                spi_errors++;
            end
        end else if (!spi_sck && prev_sck && mosi_bits == 32) begin
            spi_miso = flash_answer(cmd_sr, miso_bits);
            miso_bits++;
        end
        prev_sck = spi_sck;
    end

    // five devices, each with its own init and done delays
    always @(negedge clk) begin
        cycle++;
        if (!c_progb && t_fall < 0) t_fall = cycle;
        if (c_progb && t_fall >= 0 && t_rise < 0) t_rise = cycle;
        if (t_bits < 0 && t_rise >= 0 && pulses == 8 * int'(byte_count)) t_bits = cycle;
        for (int ch = 0; ch < NCH; ch++) begin
            initb[ch] = !(t_fall >= 0 && cycle >= t_fall + low_dly[ch] &&
                          !(t_rise >= 0 && cycle >= t_rise + rel_dly[ch]));
            prog_done[ch] = (t_bits >= 0 && cycle >= t_bits + done_dly[ch]);
        end
        busy = busy_mode && t_rise >= 0 && t_bits < 0 && ($urandom % 3 == 0);
    end

    task automatic run_load(input logic random_busy);
        int limit;
        int waited;
        @(negedge clk);
        reset      = 1'b1;
        base_addr  = flash_addr_t'($urandom % IMG_SIZE);
        byte_count = byte_count_t'(8 + $urandom % 9);
        @(posedge clk);
        t_fall    = -1;
        t_rise    = -1;
        t_bits    = -1;
        pulses    = 0;
        busy_mode = random_busy;
        for (int ch = 0; ch < NCH; ch++) begin
            low_dly[ch]  = 1 + $urandom % 10;
            rel_dly[ch]  = 2 + 3 * ch + $urandom % 8;  // staggered release
            done_dly[ch] = 1 + $urandom % 24;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (5) @(negedge clk);  // idle window before start
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        limit  = 40 * int'(byte_count) + 400;
        waited = 0;
        while (!cfg_done && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (!cfg_done) begin
            $display("timeout: cfg_done never arrived within %0d cycles", limit);
            timeouts++;
        end else begin
            repeat (20) @(posedge clk);  // done must hold
        end
    endtask

    initial begin
        reset      = 1'b1;
        start      = 1'b0;
        base_addr  = '0;
        byte_count = byte_count_t'(8);
        initb      = '1;
        prog_done  = '0;
        busy       = 1'b0;
        spi_miso   = 1'b1;
        void'($urandom(32'hd71f));
        for (int i = 0; i < IMG_SIZE; i++) begin
            flash_mem[i] = cfg_byte_t'($urandom);
        end
        image_ready = 1'b1;
        run_load(1'b0);
        if (timeouts == 0) begin
            run_load(1'b1);
        end
        assert_fails = chan_config_top_inst.spi_flash_reader_inst.reader_credit_chk.assert_fails
                     + chan_config_top_inst.bit_serializer_inst.queue_credit_chk.assert_fails;
        $display("summary: %0d bits compared, %0d check errors, %0d spi errors, %0d assertion failures, %0d timeouts",
                 bits_checked, errors, spi_errors, assert_fails, timeouts);
        if (errors == 0 && spi_errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/cfg_pkg.sv
source/bitstream_if.sv
source/spi_flash_reader.sv
source/bit_serializer.sv
source/prog_sequencer.sv
source/chan_config_top.sv
tests/chan_config_checker.sv
tests/chan_config_monitor.sv
tests/chan_config_tb.sv

/* Bender.yml */
package:
  name: chan_config

sources:
  - include_dirs:
      - source
    files:
      - source/cfg_pkg.sv
      - source/bitstream_if.sv
      - source/spi_flash_reader.sv
      - source/bit_serializer.sv
      - source/prog_sequencer.sv
      - source/chan_config_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/chan_config_checker.sv
      - tests/chan_config_monitor.sv
      - tests/chan_config_tb.sv
